// File: glb_settings.svh
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// row geometry
`define GLB_NUM_TILES 4
`define GLB_CGRA_PER_TILE 2

// bank word and word index
`define GLB_BANK_DATA_WIDTH 64
`define GLB_BANK_WORD_ADDR_WIDTH 8

// upper address bits pick the tile
`define GLB_TILE_SEL_WIDTH 2

// fabric configuration bus
`define GLB_CFG_ADDR_WIDTH 32
`define GLB_CFG_DATA_WIDTH 32

// column field starts here in a configuration address
`define GLB_CFG_COL_LSB 8

// byte lane select within one bank word
`define GLB_BYTE_OFFSET_WIDTH ($clog2(`GLB_BANK_DATA_WIDTH / 8))

// processor address, low to high: byte offset, word index, tile select
`define GLB_ADDR_WIDTH \
    (`GLB_BYTE_OFFSET_WIDTH + `GLB_BANK_WORD_ADDR_WIDTH + `GLB_TILE_SEL_WIDTH)

`endif

// File: glb_pkg.sv
`include "glb_settings.svh"

package glb_pkg;

    // one bank word and its byte strobe
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [`GLB_BANK_DATA_WIDTH/8-1:0] bank_strb_t;

    // processor byte address
    typedef logic [`GLB_ADDR_WIDTH-1:0] glb_addr_t;

    // address fields once split
    typedef logic [`GLB_BANK_WORD_ADDR_WIDTH-1:0] bank_word_addr_t;
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0] tile_id_t;

    // fabric configuration words
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data_t;

endpackage

// File: glb_bank.sv
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_bank
    import glb_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            wr_en,
    input  bank_strb_t      wr_strb,
    input  bank_word_addr_t wr_addr,
    input  bank_data_t      wr_data,

    input  logic            rd_en,
    input  bank_word_addr_t rd_addr,
    output bank_data_t      rd_data,
    output logic            rd_data_valid
);

    localparam int DEPTH     = 1 << `GLB_BANK_WORD_ADDR_WIDTH;
    localparam int NUM_BYTES = `GLB_BANK_DATA_WIDTH / 8;

    bank_data_t mem [DEPTH];

    // byte lanes without a strobe keep their old value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // read port, data held until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

endmodule

// File: glb_proc_switch.sv
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_proc_switch
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic            clk,
    input  logic            rst,

    // request from the west neighbour
    input  logic            wst_wr_en,
    input  bank_strb_t      wst_wr_strb,
    input  glb_addr_t       wst_wr_addr,
    input  bank_data_t      wst_wr_data,
    input  logic            wst_rd_en,
    input  glb_addr_t       wst_rd_addr,
    input  bank_data_t      wst_rd_data,
    input  logic            wst_rd_data_valid,

    // request and response towards the east
    output logic            est_wr_en,
    output bank_strb_t      est_wr_strb,
    output glb_addr_t       est_wr_addr,
    output bank_data_t      est_wr_data,
    output logic            est_rd_en,
    output glb_addr_t       est_rd_addr,
    output bank_data_t      est_rd_data,
    output logic            est_rd_data_valid,

    // local bank access
    output logic            bank_wr_en,
    output bank_strb_t      bank_wr_strb,
    output bank_word_addr_t bank_wr_addr,
    output bank_data_t      bank_wr_data,
    output logic            bank_rd_en,
    output bank_word_addr_t bank_rd_addr,
    input  bank_data_t      bank_rd_data,
    input  logic            bank_rd_data_valid
);

    localparam tile_id_t TILE_SEL = tile_id_t'(TILE_ID);
    localparam int WORD_LSB = `GLB_BYTE_OFFSET_WIDTH;

    logic       wr_en_q;
    bank_strb_t wr_strb_q;
    glb_addr_t  wr_addr_q;
    bank_data_t wr_data_q;
    logic       rd_en_q;
    glb_addr_t  rd_addr_q;
    bank_data_t rd_data_q;
    logic       rd_data_valid_q;
    tile_id_t   wr_tile;
    tile_id_t   rd_tile;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en_q         <= 1'b0;
            rd_en_q         <= 1'b0;
            rd_data_valid_q <= 1'b0;
        end else begin
            wr_en_q         <= wst_wr_en;
            rd_en_q         <= wst_rd_en;
            rd_data_valid_q <= wst_rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        wr_strb_q <= wst_wr_strb;
        wr_addr_q <= wst_wr_addr;
        wr_data_q <= wst_wr_data;
        rd_addr_q <= wst_rd_addr;
        rd_data_q <= wst_rd_data;
    end

    // request moves on one hop per cycle
    assign est_wr_en   = wr_en_q;
    assign est_wr_strb = wr_strb_q;
    assign est_wr_addr = wr_addr_q;
    assign est_wr_data = wr_data_q;
    assign est_rd_en   = rd_en_q;
    assign est_rd_addr = rd_addr_q;

    // tile select sits in the top address bits
    assign wr_tile = wr_addr_q[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH];
    assign rd_tile = rd_addr_q[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH];

    assign bank_wr_en   = wr_en_q && (wr_tile == TILE_SEL);
    assign bank_wr_strb = wr_strb_q;
    assign bank_wr_addr = wr_addr_q[WORD_LSB +: `GLB_BANK_WORD_ADDR_WIDTH];
    assign bank_wr_data = wr_data_q;
    assign bank_rd_en   = rd_en_q && (rd_tile == TILE_SEL);
    assign bank_rd_addr = rd_addr_q[WORD_LSB +: `GLB_BANK_WORD_ADDR_WIDTH];

    // at most one side carries a response, the bank wins the mux
    assign est_rd_data       = bank_rd_data_valid ? bank_rd_data : rd_data_q;
    assign est_rd_data_valid = bank_rd_data_valid | rd_data_valid_q;

    wr_rd_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(wr_en_q && rd_en_q)
    ) else $error("tile %0d holds a write and a read together", TILE_ID);

    // a read answered upstream can never also hit this bank
    rsp_no_collision: assert property (
        @(posedge clk) disable iff (rst) !(rd_data_valid_q && bank_rd_data_valid)
    ) else $error("tile %0d response collision", TILE_ID);

endmodule

// File: glb_tile.sv
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_tile
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic                               clk,
    input  logic                               rst,

    // processor link, west side
    input  logic                               wst_wr_en,
    input  bank_strb_t                         wst_wr_strb,
    input  glb_addr_t                          wst_wr_addr,
    input  bank_data_t                         wst_wr_data,
    input  logic                               wst_rd_en,
    input  glb_addr_t                          wst_rd_addr,
    input  bank_data_t                         wst_rd_data,
    input  logic                               wst_rd_data_valid,

    // processor link, east side
    output logic                               est_wr_en,
    output bank_strb_t                         est_wr_strb,
    output glb_addr_t                          est_wr_addr,
    output bank_data_t                         est_wr_data,
    output logic                               est_rd_en,
    output glb_addr_t                          est_rd_addr,
    output bank_data_t                         est_rd_data,
    output logic                               est_rd_data_valid,

    // configuration relay
    input  logic                               cfg_wst_wr_en,
    input  logic                               cfg_wst_rd_en,
    input  cfg_addr_t                          cfg_wst_addr,
    input  cfg_data_t                          cfg_wst_data,
    output logic                               cfg_est_wr_en,
    output logic                               cfg_est_rd_en,
    output cfg_addr_t                          cfg_est_addr,
    output cfg_data_t                          cfg_est_data,

    // configuration to this tile's fabric columns
    output logic [`GLB_CGRA_PER_TILE-1:0]      cgra_cfg_g2f_cfg_wr_en,
    output logic [`GLB_CGRA_PER_TILE-1:0]      cgra_cfg_g2f_cfg_rd_en,
    output cfg_addr_t [`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_addr,
    output cfg_data_t [`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_data
);

    localparam int COL_WIDTH = $clog2(`GLB_NUM_TILES * `GLB_CGRA_PER_TILE);

    logic            bank_wr_en;
    bank_strb_t      bank_wr_strb;
    bank_word_addr_t bank_wr_addr;
    bank_data_t      bank_wr_data;
    logic            bank_rd_en;
    bank_word_addr_t bank_rd_addr;
    bank_data_t      bank_rd_data;
    logic            bank_rd_data_valid;

    logic                 cfg_wr_en_q;
    logic                 cfg_rd_en_q;
    cfg_addr_t            cfg_addr_q;
    cfg_data_t            cfg_data_q;
    logic [COL_WIDTH-1:0] cfg_col;

    glb_proc_switch #(
        .TILE_ID (TILE_ID)
    ) glb_proc_switch (
        .*
    );

    glb_bank glb_bank (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (bank_wr_en),
        .wr_strb       (bank_wr_strb),
        .wr_addr       (bank_wr_addr),
        .wr_data       (bank_wr_data),
        .rd_en         (bank_rd_en),
        .rd_addr       (bank_rd_addr),
        .rd_data       (bank_rd_data),
        .rd_data_valid (bank_rd_data_valid)
    );

    // one register stage per tile on the config path
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_wr_en_q <= 1'b0;
            cfg_rd_en_q <= 1'b0;
        end else begin
            cfg_wr_en_q <= cfg_wst_wr_en;
            cfg_rd_en_q <= cfg_wst_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        cfg_addr_q <= cfg_wst_addr;
        cfg_data_q <= cfg_wst_data;
    end

    assign cfg_est_wr_en = cfg_wr_en_q;
    assign cfg_est_rd_en = cfg_rd_en_q;
    assign cfg_est_addr  = cfg_addr_q;
    assign cfg_est_data  = cfg_data_q;

    assign cfg_col = cfg_addr_q[`GLB_CFG_COL_LSB +: COL_WIDTH];

    // global column number of each local column
    for (genvar j = 0; j < `GLB_CGRA_PER_TILE; j++) begin : col_gen
        localparam int COL_ID = TILE_ID * `GLB_CGRA_PER_TILE + j;
        assign cgra_cfg_g2f_cfg_wr_en[j] = cfg_wr_en_q && (cfg_col == COL_WIDTH'(COL_ID));
        assign cgra_cfg_g2f_cfg_rd_en[j] = cfg_rd_en_q && (cfg_col == COL_WIDTH'(COL_ID));
        assign cgra_cfg_g2f_cfg_addr[j]  = cfg_addr_q;
        assign cgra_cfg_g2f_cfg_data[j]  = cfg_data_q;
    end

    col_en_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({cgra_cfg_g2f_cfg_wr_en, cgra_cfg_g2f_cfg_rd_en})
    ) else $error("tile %0d enables more than one column", TILE_ID);

endmodule

// File: global_buffer.sv
`timescale 1ns/1ps
`include "glb_settings.svh"

module global_buffer
    import glb_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // processor
    input  logic       proc_wr_en,
    input  bank_strb_t proc_wr_strb,
    input  glb_addr_t  proc_wr_addr,
    input  bank_data_t proc_wr_data,
    input  logic       proc_rd_en,
    input  glb_addr_t  proc_rd_addr,
    output bank_data_t proc_rd_data,
    output logic       proc_rd_data_valid,

    // configuration from the global controller
    input  logic      cgra_cfg_jtag_wr_en,
    input  logic      cgra_cfg_jtag_rd_en,
    input  cfg_addr_t cgra_cfg_jtag_addr,
    input  cfg_data_t cgra_cfg_jtag_data,

    // configuration to the fabric
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0]      cgra_cfg_g2f_cfg_wr_en,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0]      cgra_cfg_g2f_cfg_rd_en,
    output cfg_addr_t [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_addr,
    output cfg_data_t [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_data
);

    localparam int NT = `GLB_NUM_TILES;

    // index k is the west side of tile k, index NT the east end of the row
    logic       wr_en_link        [NT+1];
    bank_strb_t wr_strb_link      [NT+1];
    glb_addr_t  wr_addr_link      [NT+1];
    bank_data_t wr_data_link      [NT+1];
    logic       rd_en_link        [NT+1];
    glb_addr_t  rd_addr_link      [NT+1];
    bank_data_t rd_data_link      [NT+1];
    logic       rd_data_valid_link[NT+1];

    logic      cfg_wr_en_link[NT+1];
    logic      cfg_rd_en_link[NT+1];
    cfg_addr_t cfg_addr_link [NT+1];
    cfg_data_t cfg_data_link [NT+1];

    // west edge
    assign wr_en_link[0]         = proc_wr_en;
    assign wr_strb_link[0]       = proc_wr_strb;
    assign wr_addr_link[0]       = proc_wr_addr;
    assign wr_data_link[0]       = proc_wr_data;
    assign rd_en_link[0]         = proc_rd_en;
    assign rd_addr_link[0]       = proc_rd_addr;
    assign rd_data_link[0]       = '0;
    assign rd_data_valid_link[0] = 1'b0;

    assign cfg_wr_en_link[0] = cgra_cfg_jtag_wr_en;
    assign cfg_rd_en_link[0] = cgra_cfg_jtag_rd_en;
    assign cfg_addr_link[0]  = cgra_cfg_jtag_addr;
    assign cfg_data_link[0]  = cgra_cfg_jtag_data;

    // east edge returns the response
    assign proc_rd_data       = rd_data_link[NT];
    assign proc_rd_data_valid = rd_data_valid_link[NT];

    for (genvar i = 0; i < NT; i++) begin : glb_tile_gen
        glb_tile #(
            .TILE_ID (i)
        ) glb_tile (
            .clk                    (clk),
            .rst                    (rst),
            .wst_wr_en              (wr_en_link[i]),
            .wst_wr_strb            (wr_strb_link[i]),
            .wst_wr_addr            (wr_addr_link[i]),
            .wst_wr_data            (wr_data_link[i]),
            .wst_rd_en              (rd_en_link[i]),
            .wst_rd_addr            (rd_addr_link[i]),
            .wst_rd_data            (rd_data_link[i]),
            .wst_rd_data_valid      (rd_data_valid_link[i]),
            .est_wr_en              (wr_en_link[i+1]),
            .est_wr_strb            (wr_strb_link[i+1]),
            .est_wr_addr            (wr_addr_link[i+1]),
            .est_wr_data            (wr_data_link[i+1]),
            .est_rd_en              (rd_en_link[i+1]),
            .est_rd_addr            (rd_addr_link[i+1]),
            .est_rd_data            (rd_data_link[i+1]),
            .est_rd_data_valid      (rd_data_valid_link[i+1]),
            .cfg_wst_wr_en          (cfg_wr_en_link[i]),
            .cfg_wst_rd_en          (cfg_rd_en_link[i]),
            .cfg_wst_addr           (cfg_addr_link[i]),
            .cfg_wst_data           (cfg_data_link[i]),
            .cfg_est_wr_en          (cfg_wr_en_link[i+1]),
            .cfg_est_rd_en          (cfg_rd_en_link[i+1]),
            .cfg_est_addr           (cfg_addr_link[i+1]),
            .cfg_est_data           (cfg_data_link[i+1]),
            .cgra_cfg_g2f_cfg_wr_en (cgra_cfg_g2f_cfg_wr_en[i]),
            .cgra_cfg_g2f_cfg_rd_en (cgra_cfg_g2f_cfg_rd_en[i]),
            .cgra_cfg_g2f_cfg_addr  (cgra_cfg_g2f_cfg_addr[i]),
            .cgra_cfg_g2f_cfg_data  (cgra_cfg_g2f_cfg_data[i])
        );
    end

endmodule

// File: global_buffer_tb.sv
`timescale 1ns/1ps
`include "glb_settings.svh"

module global_buffer_tb
    import glb_pkg::*;
();

    localparam int NT         = `GLB_NUM_TILES;
    localparam int CPT        = `GLB_CGRA_PER_TILE;
    localparam int DW         = `GLB_BANK_DATA_WIDTH;
    localparam int NB         = DW / 8;
    localparam int DEPTH      = 1 << `GLB_BANK_WORD_ADDR_WIDTH;
    localparam int OFF_W      = `GLB_BYTE_OFFSET_WIDTH;
    localparam int COL_LSB    = `GLB_CFG_COL_LSB;
    localparam int COL_W      = $clog2(NT * CPT);
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;

    localparam int N_IDLE      = 20;
    localparam int N_FULL      = 64;
    localparam int N_PART      = 64;
    localparam int N_B2B       = 200;
    localparam int N_PAIR      = 64;
    localparam int N_CFG       = 120;
    localparam int DRAIN_LIMIT = 4 * NT + 16;
    // five tests close with a drain and two idle cycles
    localparam int TEST_CYCLES = N_IDLE + NT * DEPTH + 2 * N_FULL + 2 * N_PART + N_B2B
        + 2 * N_PAIR + 2 * N_CFG + 5 * (DRAIN_LIMIT + 2);
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 500;

    logic       clk;
    logic       rst;
    logic       proc_wr_en;
    bank_strb_t proc_wr_strb;
    glb_addr_t  proc_wr_addr;
    bank_data_t proc_wr_data;
    logic       proc_rd_en;
    glb_addr_t  proc_rd_addr;
    bank_data_t proc_rd_data;
    logic       proc_rd_data_valid;
    logic       cgra_cfg_jtag_wr_en;
    logic       cgra_cfg_jtag_rd_en;
    cfg_addr_t  cgra_cfg_jtag_addr;
    cfg_data_t  cgra_cfg_jtag_data;

    logic [NT-1:0][CPT-1:0]      cgra_cfg_g2f_cfg_wr_en;
    logic [NT-1:0][CPT-1:0]      cgra_cfg_g2f_cfg_rd_en;
    cfg_addr_t [NT-1:0][CPT-1:0] cgra_cfg_g2f_cfg_addr;
    cfg_data_t [NT-1:0][CPT-1:0] cgra_cfg_g2f_cfg_data;

    // byte image of every bank
    logic [7:0] img [NT][DEPTH][NB];

    // expected read responses, stamped with the cycle they are due
    int         rd_due_q[$];
    bank_data_t rd_exp_q[$];

    // expected configuration outputs
    int        cfg_due_q[$];
    int        cfg_tile_q[$];
    int        cfg_col_q[$];
    bit        cfg_is_wr_q[$];
    cfg_addr_t cfg_addr_exp_q[$];
    cfg_data_t cfg_data_exp_q[$];

    int    seed;
    int    cyc;
    int    err_cnt;
    int    test_err_base;
    int    tests_run;
    int    tests_failed;
    bit    check_on;
    string cur_test;

    global_buffer dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // outputs are sampled mid-cycle, well away from both edges
    always @(negedge clk) begin
        if (check_on) begin
            check_read_port();
            check_cfg_port();
        end
    end

    task automatic value_error(string what, logic [63:0] exp, logic [63:0] act);
        $display("Error %s: %s expected %0h actual %0h", cur_test, what, exp, act);
        err_cnt++;
    endtask

    task automatic plain_error(string msg);
        $display("Error %s: %s", cur_test, msg);
        err_cnt++;
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic bank_data_t rand_word();
        bank_data_t w;
        for (int k = 0; k < DW / 32; k++) begin
            w[k*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    // byte offset, then word index, then tile select
    function automatic glb_addr_t make_addr(int tile, int word, int off);
        return {tile_id_t'(tile), bank_word_addr_t'(word), OFF_W'(off)};
    endfunction

    // every lane mixes tile and word
    function automatic bank_data_t fill_pattern(int tile, int word);
        logic [15:0] base;
        bank_data_t  w;
        base = {8'(tile), 8'(word)};
        for (int k = 0; k < DW / 16; k++) begin
            w[k*16 +: 16] = base ^ (16'h5a5a + 16'(k) * 16'h1111);
        end
        return w;
    endfunction

    function automatic void model_write(int tile, int word, bank_strb_t strb, bank_data_t data);
        for (int b = 0; b < NB; b++) begin
            if (strb[b]) begin
                img[tile][word][b] = data[b*8 +: 8];
            end
        end
    endfunction

    function automatic bank_data_t model_word(int tile, int word);
        bank_data_t w;
        for (int b = 0; b < NB; b++) begin
            w[b*8 +: 8] = img[tile][word][b];
        end
        return w;
    endfunction

    task automatic drive_idle();
        proc_wr_en          = 1'b0;
        proc_rd_en          = 1'b0;
        cgra_cfg_jtag_wr_en = 1'b0;
        cgra_cfg_jtag_rd_en = 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
    endtask

    task automatic write_word(int tile, int word, bank_strb_t strb, bank_data_t data);
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
        proc_wr_en   = 1'b1;
        proc_wr_strb = strb;
        proc_wr_addr = make_addr(tile, word, rand_below(NB));
        proc_wr_data = data;
        model_write(tile, word, strb, data);
    endtask

    // response leaves the row NT cycles after the sampling edge
    task automatic read_word(int tile, int word);
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
        proc_rd_en   = 1'b1;
        proc_rd_addr = make_addr(tile, word, rand_below(NB));
        rd_due_q.push_back(cyc + 1 + NT);
        rd_exp_q.push_back(model_word(tile, word));
    endtask

    task automatic cfg_access(bit is_wr, int col);
        cfg_addr_t a;
        cfg_data_t d;
        a = '0;
        a[COL_LSB-1:0] = COL_LSB'($random(seed));
        a[COL_LSB +: COL_W] = COL_W'(col);
        d = cfg_data_t'($random(seed));
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
        cgra_cfg_jtag_wr_en = is_wr;
        cgra_cfg_jtag_rd_en = !is_wr;
        cgra_cfg_jtag_addr  = a;
        cgra_cfg_jtag_data  = d;
        // tile i shows the word i+1 cycles after it is driven
        cfg_due_q.push_back(cyc + 1 + col / CPT);
        cfg_tile_q.push_back(col / CPT);
        cfg_col_q.push_back(col % CPT);
        cfg_is_wr_q.push_back(is_wr);
        cfg_addr_exp_q.push_back(a);
        cfg_data_exp_q.push_back(d);
    endtask

    task automatic check_read_port();
        if (proc_rd_data_valid === 1'b1) begin
            if (rd_due_q.size() == 0 || rd_due_q[0] != cyc) begin
                plain_error($sformatf("read response arrived unexpectedly in cycle %0d", cyc));
            end else begin
                if (proc_rd_data !== rd_exp_q[0]) begin
                    value_error("read data", rd_exp_q[0], proc_rd_data);
                end
                void'(rd_due_q.pop_front());
                void'(rd_exp_q.pop_front());
            end
        end else if (proc_rd_data_valid !== 1'b0) begin
            plain_error($sformatf("read valid is unknown in cycle %0d", cyc));
        end else if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
            plain_error($sformatf("read response due in cycle %0d never came", rd_due_q[0]));
            void'(rd_due_q.pop_front());
            void'(rd_exp_q.pop_front());
        end
    endtask

    task automatic check_cfg_port();
        logic [NT*CPT-1:0] exp_wr;
        logic [NT*CPT-1:0] exp_rd;
        int                t;
        int                c;
        exp_wr = '0;
        exp_rd = '0;
        for (int k = cfg_due_q.size() - 1; k >= 0; k--) begin
            if (cfg_due_q[k] == cyc) begin
                t = cfg_tile_q[k];
                c = cfg_col_q[k];
                if (cfg_is_wr_q[k]) begin
                    exp_wr[t*CPT + c] = 1'b1;
                end else begin
                    exp_rd[t*CPT + c] = 1'b1;
                end
                if (cgra_cfg_g2f_cfg_addr[t][c] !== cfg_addr_exp_q[k]) begin
                    value_error("cfg addr", 64'(cfg_addr_exp_q[k]),
                        64'(cgra_cfg_g2f_cfg_addr[t][c]));
                end
                if (cgra_cfg_g2f_cfg_data[t][c] !== cfg_data_exp_q[k]) begin
                    value_error("cfg data", 64'(cfg_data_exp_q[k]),
                        64'(cgra_cfg_g2f_cfg_data[t][c]));
                end
                cfg_due_q.delete(k);
                cfg_tile_q.delete(k);
                cfg_col_q.delete(k);
                cfg_is_wr_q.delete(k);
                cfg_addr_exp_q.delete(k);
                cfg_data_exp_q.delete(k);
            end
        end
        if (cgra_cfg_g2f_cfg_wr_en !== exp_wr) begin
            value_error("cfg wr_en", 64'(exp_wr), 64'(cgra_cfg_g2f_cfg_wr_en));
        end
        if (cgra_cfg_g2f_cfg_rd_en !== exp_rd) begin
            value_error("cfg rd_en", 64'(exp_rd), 64'(cgra_cfg_g2f_cfg_rd_en));
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((rd_due_q.size() != 0 || cfg_due_q.size() != 0) && n < DRAIN_LIMIT) begin
            idle_cycle();
            n++;
        end
        if (rd_due_q.size() != 0 || cfg_due_q.size() != 0) begin
            plain_error("responses still outstanding after the drain limit");
            rd_due_q.delete();
            rd_exp_q.delete();
            cfg_due_q.delete();
            cfg_tile_q.delete();
            cfg_col_q.delete();
            cfg_is_wr_q.delete();
            cfg_addr_exp_q.delete();
            cfg_data_exp_q.delete();
        end
        repeat (2) idle_cycle();
    endtask

    task automatic begin_test(string name);
        cur_test      = name;
        test_err_base = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == test_err_base) begin
            $display("test %-12s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", cur_test, err_cnt - test_err_base);
        end
    endtask

    initial begin
        int         t_list[$];
        int         w_list[$];
        int         t;
        int         w;
        bank_strb_t s;

        seed         = 32'hf532ea0f;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        check_on     = 1'b0;
        cur_test     = "reset";
        rst          = 1'b1;
        drive_idle();
        proc_wr_strb       = '0;
        proc_wr_addr       = '0;
        proc_wr_data       = '0;
        proc_rd_addr       = '0;
        cgra_cfg_jtag_addr = '0;
        cgra_cfg_jtag_data = '0;

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst      = 1'b0;
        check_on = 1'b1;

        // monitor flags any valid or enable while nothing is queued
        begin_test("after_reset");
        repeat (N_IDLE) idle_cycle();
        end_test();

        begin_test("full_word");
        for (int i = 0; i < NT * DEPTH; i++) begin
            write_word(i / DEPTH, i % DEPTH, '1, fill_pattern(i / DEPTH, i % DEPTH));
        end
        for (int i = 0; i < N_FULL; i++) begin
            t = i % NT;
            w = rand_below(DEPTH);
            write_word(t, w, '1, rand_word());
            t_list.push_back(t);
            w_list.push_back(w);
        end
        for (int i = 0; i < N_FULL; i++) begin
            read_word(t_list[i], w_list[i]);
        end
        wait_drain();
        end_test();

        begin_test("partial");
        t_list.delete();
        w_list.delete();
        for (int i = 0; i < N_PART; i++) begin
            t = rand_below(NT);
            w = rand_below(DEPTH);
            s = bank_strb_t'($random(seed));
            write_word(t, w, s, rand_word());
            t_list.push_back(t);
            w_list.push_back(w);
        end
        for (int i = 0; i < N_PART; i++) begin
            read_word(t_list[i], w_list[i]);
        end
        wait_drain();
        end_test();

        begin_test("back_to_back");
        for (int i = 0; i < N_B2B; i++) begin
            read_word(rand_below(NT), rand_below(DEPTH));
        end
        wait_drain();
        end_test();

        begin_test("wr_then_rd");
        for (int i = 0; i < N_PAIR; i++) begin
            t = rand_below(NT);
            w = rand_below(DEPTH);
            s = bank_strb_t'($random(seed));
            write_word(t, w, s, rand_word());
            read_word(t, w);
        end
        wait_drain();
        end_test();

        begin_test("config");
        for (int i = 0; i < N_CFG; i++) begin
            cfg_access(rand_below(2) == 1, rand_below(NT * CPT));
            if (rand_below(3) == 0) begin
                idle_cycle();
            end
        end
        wait_drain();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: global_buffer.f
+incdir+.
glb_pkg.sv
glb_bank.sv
glb_proc_switch.sv
glb_tile.sv
global_buffer.sv
global_buffer_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= global_buffer_tb
FILELIST   ?= global_buffer.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) glb_settings.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "Simulation PASSED" $(LOG); then \
		echo "run passed, log in $(LOG)"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
